// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= rrag_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Register file geometry.
    localparam int num_regs  = 8;
    localparam int reg_idx_w = $clog2(num_regs);
    localparam int gpr_w     = 32;
    localparam int seg_w     = 16;

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // Access size in bytes is 1 << value.
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2,
        size_qword = 2'd3
    } op_size_e;

    // SIB scale serves directly as a shift amount.
    typedef enum logic [1:0] {
        scale_1 = 2'd0,
        scale_2 = 2'd1,
        scale_4 = 2'd2,
        scale_8 = 2'd3
    } scale_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_read  = 2'd1,
        mem_write = 2'd2,
        mem_rmw   = 2'd3
    } mem_rw_e;

endpackage

`default_nettype wire

// File: common/rrag_pkg.sv
`default_nettype none

package rrag_pkg;

    import isa_pkg::*;

    localparam int tag_w = 7;

    // Read port counts and port indices.
    localparam int gpr_ports = 3;
    localparam int seg_ports = 2;
    localparam int rd_base   = 0;
    localparam int rd_idx    = 1;
    localparam int rd_ptr2   = 2;
    localparam int rd_seg1   = 0;
    localparam int rd_seg2   = 1;

    typedef logic [tag_w-1:0] tag_t;

    typedef struct packed {
        reg_idx_t              base_addr;
        reg_idx_t              idx_addr;
        reg_idx_t              ptr2_addr;
        reg_idx_t              seg1_addr;
        reg_idx_t              seg2_addr;
        logic                  use_base;
        logic                  use_idx;
        logic                  is_rep;
        scale_e                scale;
        op_size_e              size;
        mem_rw_e               mem1_rw;
        mem_rw_e               mem2_rw;
        logic [gpr_w-1:0]      disp;
        logic [num_regs-1:0]   gpr_dest; // One bit per register.
        logic [num_regs-1:0]   seg_dest;
    } agen_req_t;

    typedef struct packed {
        logic             en;
        reg_idx_t         addr;
        logic [gpr_w-1:0] data;
        tag_t             tag;
    } gpr_wb_t;

    typedef struct packed {
        logic             en;
        reg_idx_t         addr;
        logic [seg_w-1:0] data;
        tag_t             tag;
    } seg_wb_t;

    typedef struct packed {
        logic [gpr_w-1:0] mem_addr1;
        logic [gpr_w-1:0] mem_addr1_end;
        logic [gpr_w-1:0] mem_addr2;
        logic [gpr_w-1:0] mem_addr2_end;
        logic [gpr_w-1:0] rep_num;
        logic [gpr_w-1:0] base_val;
        logic [gpr_w-1:0] idx_val;
        logic [gpr_w-1:0] ptr2_val;
        op_size_e         size;
        tag_t             tag;
    } agen_rsp_t;

endpackage

`default_nettype wire

// File: dv/rrag_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rrag_chk (
    input logic                         clk,
    input logic                         arst_n,
    input rrag_pkg::agen_req_t          req,
    input logic                         valid_out,
    input logic                         stall,
    input logic                         latch_empty,
    input logic                         fwd_stall,
    input logic                         ptc_clear,
    input rrag_pkg::tag_t               tag,
    input logic [isa_pkg::num_regs-1:0] gpr_pend,
    input logic [isa_pkg::num_regs-1:0] seg_pend
);
    import isa_pkg::*;
    import rrag_pkg::*;

    logic addr1_blocked;
    logic addr2_blocked;
    int   rule_fails  = 0;
    int   valid_fails = 0;
    int   empty_fails = 0;
    int   hold_fails  = 0;
    int   step_fails  = 0;
    int   clear_fails = 0;
    int   fail_cnt;

    // Pending state of every register, picked by the request's own addresses.
    assign addr1_blocked = (req.mem1_rw != mem_none) && (seg_pend[req.seg1_addr]
        || (req.use_base && gpr_pend[req.base_addr])
        || (req.use_idx && gpr_pend[req.idx_addr]));
    assign addr2_blocked = (req.mem2_rw != mem_none)
        && (seg_pend[req.seg2_addr] || gpr_pend[req.ptr2_addr]);
    assign fail_cnt = rule_fails + valid_fails + empty_fails + hold_fails + step_fails
                      + clear_fails;

    a_stall_rule: assert property (@(posedge clk) disable iff (!arst_n)
        stall == (fwd_stall || addr1_blocked || addr2_blocked))
        else begin
            $error("stall does not match the pending address registers");
            rule_fails++;
        end

    a_no_valid_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> !valid_out)
        else begin
            $error("valid_out high while stalled");
            valid_fails++;
        end

    a_no_valid_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
        latch_empty |-> !valid_out)
        else begin
            $error("valid_out high while the latch is empty");
            empty_fails++;
        end

    a_tag_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !valid_out |=> $stable(tag))
        else begin
            $error("tag changed without an issue");
            hold_fails++;
        end

    a_tag_step: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out |=> (tag != $past(tag)) && (tag != '0))
        else begin
            $error("tag did not advance to a nonzero value after an issue");
            step_fails++;
        end

    a_clear_drops_pending: assert property (@(posedge clk) disable iff (!arst_n)
        ptc_clear |=> (gpr_pend == '0) && (seg_pend == '0))
        else begin
            $error("pending bits survived a clear");
            clear_fails++;
        end

endmodule

`default_nettype wire

// File: dv/rrag_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rrag_tb;
    import isa_pkg::*;
    import rrag_pkg::*;

    localparam int fill_cycles  = 16;
    localparam int addr_cycles  = 800;
    localparam int score_cycles = 1200;
    localparam int max_cycles   = 3000; // About 2000 stimulus cycles plus margin.

    logic                clk;
    logic                arst_n;
    agen_req_t           req;
    logic                valid_in;
    logic                latch_empty;
    logic                fwd_stall;
    logic                ptc_clear;
    gpr_wb_t             gpr_wb;
    seg_wb_t             seg_wb;
    agen_rsp_t           rsp;
    logic                valid_out;
    logic                stall;
    logic [31:0]         lfsr_q = 32'hbd7a_0c7e;
    logic [gpr_w-1:0]    gpr_m [num_regs];
    logic [seg_w-1:0]    seg_m [num_regs];
    tag_t                gtag_m [num_regs];
    tag_t                stag_m [num_regs];
    logic [num_regs-1:0] gpend_m;
    logic [num_regs-1:0] spend_m;
    tag_t                tag_m;
    logic                exp_valid;
    logic                exp_stall;
    int                  cycles;
    int                  tb_errors;

    rrag u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .valid_in    (valid_in),
        .latch_empty (latch_empty),
        .fwd_stall   (fwd_stall),
        .gpr_wb      (gpr_wb),
        .seg_wb      (seg_wb),
        .ptc_clear   (ptc_clear),
        .rsp         (rsp),
        .valid_out   (valid_out),
        .stall       (stall)
    );

    bind rrag rrag_chk u_chk (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .valid_out   (valid_out),
        .stall       (stall),
        .latch_empty (latch_empty),
        .fwd_stall   (fwd_stall),
        .ptc_clear   (ptc_clear),
        .tag         (rsp.tag),
        .gpr_pend    (u_gpr_file.pend_q),
        .seg_pend    (u_seg_file.pend_q)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            tb_errors++;
        end
    endtask

    task automatic randomize_req(input logic with_dest);
        req.base_addr = reg_idx_t'(take_bits(3));
        req.idx_addr  = reg_idx_t'(take_bits(3));
        req.ptr2_addr = reg_idx_t'(take_bits(3));
        req.seg1_addr = reg_idx_t'(take_bits(3));
        req.seg2_addr = reg_idx_t'(take_bits(3));
        req.use_base  = 1'(take_bits(1));
        req.use_idx   = 1'(take_bits(1));
        req.is_rep    = 1'(take_bits(1));
        req.scale     = scale_e'(take_bits(2));
        req.size      = op_size_e'(take_bits(2));
        req.mem1_rw   = mem_rw_e'(take_bits(2));
        req.mem2_rw   = mem_rw_e'(take_bits(2));
        req.disp      = take_bits(32);
        req.gpr_dest  = with_dest ? 8'(take_bits(8) & take_bits(8) & take_bits(8)) : 8'h00;
        req.seg_dest  = with_dest ? 8'(take_bits(8) & take_bits(8) & take_bits(8)) : 8'h00;
    endtask

    task automatic drive_inputs(input int n);
        int   fill_idx;
        logic hold;
        fill_idx  = n % num_regs;
        hold      = exp_stall && valid_in;
        gpr_wb    = '0;
        seg_wb    = '0;
        fwd_stall = 1'b0;
        ptc_clear = 1'b0;
        if (n < fill_cycles) begin
            gpr_wb.en   = 1'b1;
            gpr_wb.addr = reg_idx_t'(fill_idx);
            gpr_wb.data = (fill_idx == 7) ? 32'hffff_fffd : take_bits(32); // Near the top.
            seg_wb.en   = 1'b1;
            seg_wb.addr = reg_idx_t'(fill_idx);
            seg_wb.data = (fill_idx == 0) ? 16'h0000 : 16'(take_bits(16));
            valid_in    = 1'b0;
        end else if (n < fill_cycles + addr_cycles) begin
            randomize_req(1'b0);
            if (n % 8 == 0) begin
                req.use_base  = 1'b0; // End address wraps past 32 bits.
                req.use_idx   = 1'b0;
                req.seg1_addr = reg_idx_t'(0);
                req.seg2_addr = reg_idx_t'(0);
                req.ptr2_addr = reg_idx_t'(7);
                req.disp      = 32'hffff_fff8 | take_bits(3);
            end
            valid_in    = 1'(take_bits(1));
            latch_empty = (take_bits(3) == 0);
        end else begin
            if (!hold) begin
                randomize_req(1'b1);
            end
            valid_in    = (take_bits(2) != 0);
            latch_empty = (take_bits(3) == 0);
            fwd_stall   = (take_bits(4) == 0);
            ptc_clear   = (take_bits(6) == 0);
            gpr_wb.en   = 1'(take_bits(1));
            gpr_wb.addr = reg_idx_t'(take_bits(3));
            gpr_wb.data = take_bits(32);
            gpr_wb.tag  = (take_bits(2) != 0) ? gtag_m[gpr_wb.addr] : gtag_m[gpr_wb.addr] + 1'b1;
            seg_wb.en   = 1'(take_bits(1));
            seg_wb.addr = reg_idx_t'(take_bits(3));
            seg_wb.data = 16'(take_bits(16));
            seg_wb.tag  = (take_bits(2) != 0) ? stag_m[seg_wb.addr] : stag_m[seg_wb.addr] + 1'b1;
        end
    endtask

    // Applied at the edge, lowest priority first.
    task automatic update_model();
        for (int i = 0; i < num_regs; i++) begin
            if (gpr_wb.en && gpr_wb.addr == reg_idx_t'(i)) begin
                gpr_m[i] = gpr_wb.data;
                if (gpr_wb.tag == gtag_m[i]) gpend_m[i] = 1'b0;
            end
            if (seg_wb.en && seg_wb.addr == reg_idx_t'(i)) begin
                seg_m[i] = seg_wb.data;
                if (seg_wb.tag == stag_m[i]) spend_m[i] = 1'b0;
            end
            if (exp_valid && req.gpr_dest[i]) begin
                gpend_m[i] = 1'b1;
                gtag_m[i]  = tag_m;
            end
            if (exp_valid && req.seg_dest[i]) begin
                spend_m[i] = 1'b1;
                stag_m[i]  = tag_m;
            end
        end
        if (ptc_clear) begin
            gpend_m = '0;
            spend_m = '0;
        end
        if (exp_valid) tag_m = (tag_m == '1) ? tag_t'(1) : tag_m + 1'b1;
    endtask

    task automatic check_outputs();
        logic [31:0] off1;
        logic [31:0] addr1;
        logic [31:0] addr2;
        logic [31:0] last;
        logic [31:0] ptr2;
        logic        blk1;
        logic        blk2;
        ptr2 = gpr_m[req.ptr2_addr];
        off1 = req.disp;
        if (req.use_base) off1 += gpr_m[req.base_addr];
        if (req.use_idx) off1 += gpr_m[req.idx_addr] * (32'd1 << req.scale);
        addr1 = off1 + {seg_m[req.seg1_addr], 16'h0000};
        addr2 = ptr2 + {seg_m[req.seg2_addr], 16'h0000};
        last  = (32'd1 << req.size) - 32'd1;
        blk1  = (req.mem1_rw != mem_none) && ((req.use_base && gpend_m[req.base_addr])
                || (req.use_idx && gpend_m[req.idx_addr]) || spend_m[req.seg1_addr]);
        blk2  = (req.mem2_rw != mem_none) && (gpend_m[req.ptr2_addr] || spend_m[req.seg2_addr]);
        exp_stall = fwd_stall || blk1 || blk2;
        exp_valid = valid_in && !latch_empty && !exp_stall;
        compare_value("rsp.mem_addr1", rsp.mem_addr1, addr1);
        compare_value("rsp.mem_addr1_end", rsp.mem_addr1_end, addr1 + last);
        compare_value("rsp.mem_addr2", rsp.mem_addr2, addr2);
        compare_value("rsp.mem_addr2_end", rsp.mem_addr2_end, addr2 + last);
        compare_value("rsp.rep_num", rsp.rep_num, req.is_rep ? ptr2 : 32'h0);
        compare_value("rsp.base_val", rsp.base_val, gpr_m[req.base_addr]);
        compare_value("rsp.idx_val", rsp.idx_val, gpr_m[req.idx_addr]);
        compare_value("rsp.ptr2_val", rsp.ptr2_val, ptr2);
        compare_value("rsp.size", 32'(rsp.size), 32'(req.size));
        compare_value("rsp.tag", 32'(rsp.tag), 32'(tag_m));
        compare_value("stall", 32'(stall), 32'(exp_stall));
        compare_value("valid_out", 32'(valid_out), 32'(exp_valid));
    endtask

    initial begin
        arst_n      = 1'b0;
        req         = '0;
        valid_in    = 1'b0;
        latch_empty = 1'b1;
        fwd_stall   = 1'b0;
        ptc_clear   = 1'b0;
        gpr_wb      = '0;
        seg_wb      = '0;
        for (int i = 0; i < num_regs; i++) begin
            gpr_m[i]  = '0;
            seg_m[i]  = '0;
            gtag_m[i] = '0;
            stag_m[i] = '0;
        end
        gpend_m   = '0;
        spend_m   = '0;
        tag_m     = tag_t'(1);
        exp_valid = 1'b0;
        exp_stall = 1'b0;
        tb_errors = 0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int n = 0; n < fill_cycles + addr_cycles + score_cycles; n++) begin
            @(posedge clk);
            update_model();
            #1;
            drive_inputs(n);
            #2;
            check_outputs();
        end
        @(posedge clk);
        #1;
        $display("Errors: testbench %0d, assertions %0d", tb_errors, u_dut.u_chk.fail_cnt);
        if (tb_errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module addr_gen (
    input  rrag_pkg::agen_req_t       req,
    input  logic [isa_pkg::gpr_w-1:0] base_val,
    input  logic [isa_pkg::gpr_w-1:0] idx_val,
    input  logic [isa_pkg::gpr_w-1:0] ptr2_val,
    input  logic [isa_pkg::seg_w-1:0] seg1_val,
    input  logic [isa_pkg::seg_w-1:0] seg2_val,
    input  rrag_pkg::tag_t            tag,
    output rrag_pkg::agen_rsp_t       rsp
);
    import isa_pkg::*;

    logic [gpr_w-1:0] base_term;
    logic [gpr_w-1:0] idx_term;
    logic [gpr_w-1:0] offset1;
    logic [gpr_w-1:0] seg1_base;
    logic [gpr_w-1:0] seg2_base;
    logic [gpr_w-1:0] size_m1;
    logic [gpr_w-1:0] mem_addr1;
    logic [gpr_w-1:0] mem_addr2;

    // Segment base is the selector shifted up by 16.
    assign seg1_base = {seg1_val, {(gpr_w - seg_w){1'b0}}};
    assign seg2_base = {seg2_val, {(gpr_w - seg_w){1'b0}}};

    assign base_term = req.use_base ? base_val : '0;
    assign idx_term  = req.use_idx ? (idx_val << req.scale) : '0;
    assign offset1   = base_term + idx_term + req.disp;

    assign mem_addr1 = seg1_base + offset1; // Wraps at 32 bits.
    assign mem_addr2 = ptr2_val + seg2_base;

    // Last byte offset of the access.
    always_comb begin
        case (req.size)
            size_byte:  size_m1 = gpr_w'(0);
            size_word:  size_m1 = gpr_w'(1);
            size_dword: size_m1 = gpr_w'(3);
            default:    size_m1 = gpr_w'(7);
        endcase
    end

    always_comb begin
        rsp.mem_addr1     = mem_addr1;
        rsp.mem_addr1_end = mem_addr1 + size_m1;
        rsp.mem_addr2     = mem_addr2;
        rsp.mem_addr2_end = mem_addr2 + size_m1;
        rsp.rep_num       = req.is_rep ? ptr2_val : '0; // Count lives in the ptr2 register.
        rsp.base_val      = base_val;
        rsp.idx_val       = idx_val;
        rsp.ptr2_val      = ptr2_val;
        rsp.size          = req.size;
        rsp.tag           = tag;
    end

endmodule

`default_nettype wire

// File: logic/rrag.sv
`timescale 1ns/10ps
`default_nettype none

module rrag (
    input  logic                clk,
    input  logic                arst_n,
    input  rrag_pkg::agen_req_t req,
    input  logic                valid_in,
    input  logic                latch_empty,
    input  logic                fwd_stall,
    input  rrag_pkg::gpr_wb_t   gpr_wb,
    input  rrag_pkg::seg_wb_t   seg_wb,
    input  logic                ptc_clear,
    output rrag_pkg::agen_rsp_t rsp,
    output logic                valid_out,
    output logic                stall
);
    import isa_pkg::*;
    import rrag_pkg::*;

    tag_t                            tag_q;
    reg_idx_t [gpr_ports-1:0]        gpr_rd_addr;
    logic [gpr_ports-1:0][gpr_w-1:0] gpr_rd_data;
    logic [gpr_ports-1:0]            gpr_rd_pend;
    reg_idx_t [seg_ports-1:0]        seg_rd_addr;
    logic [seg_ports-1:0][seg_w-1:0] seg_rd_data;
    logic [seg_ports-1:0]            seg_rd_pend;
    logic                            mem1_use;
    logic                            mem2_use;
    logic                            mem1_stall;
    logic                            mem2_stall;

    assign gpr_rd_addr[rd_base] = req.base_addr;
    assign gpr_rd_addr[rd_idx]  = req.idx_addr;
    assign gpr_rd_addr[rd_ptr2] = req.ptr2_addr;
    assign seg_rd_addr[rd_seg1] = req.seg1_addr;
    assign seg_rd_addr[rd_seg2] = req.seg2_addr;

    assign mem1_use = (req.mem1_rw != mem_none);
    assign mem2_use = (req.mem2_rw != mem_none);

    // Only registers that actually feed an address can stall.
    assign mem1_stall = mem1_use && ((req.use_base && gpr_rd_pend[rd_base])
                                     || (req.use_idx && gpr_rd_pend[rd_idx])
                                     || seg_rd_pend[rd_seg1]);
    assign mem2_stall = mem2_use && (gpr_rd_pend[rd_ptr2] || seg_rd_pend[rd_seg2]);

    assign stall     = fwd_stall || mem1_stall || mem2_stall;
    assign valid_out = valid_in && !latch_empty && !stall;

    // Tag zero is never handed out.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_q <= tag_t'(1);
        end else if (valid_out) begin
            tag_q <= (tag_q == '1) ? tag_t'(1) : tag_q + tag_t'(1);
        end
    end

    gpr_file u_gpr_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr   (gpr_rd_addr),
        .wb        (gpr_wb),
        .issue     (valid_out),
        .issue_tag (tag_q),
        .dest_mask (req.gpr_dest),
        .ptc_clear (ptc_clear),
        .rd_data   (gpr_rd_data),
        .rd_pend   (gpr_rd_pend)
    );

    seg_file u_seg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr   (seg_rd_addr),
        .wb        (seg_wb),
        .issue     (valid_out),
        .issue_tag (tag_q),
        .dest_mask (req.seg_dest),
        .ptc_clear (ptc_clear),
        .rd_data   (seg_rd_data),
        .rd_pend   (seg_rd_pend)
    );

    addr_gen u_addr_gen (
        .req      (req),
        .base_val (gpr_rd_data[rd_base]),
        .idx_val  (gpr_rd_data[rd_idx]),
        .ptr2_val (gpr_rd_data[rd_ptr2]),
        .seg1_val (seg_rd_data[rd_seg1]),
        .seg2_val (seg_rd_data[rd_seg2]),
        .tag      (tag_q),
        .rsp      (rsp)
    );

endmodule

`default_nettype wire

// File: regfile/gpr_file.sv
`timescale 1ns/10ps
`default_nettype none

module gpr_file (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  isa_pkg::reg_idx_t [rrag_pkg::gpr_ports-1:0]           rd_addr,
    input  rrag_pkg::gpr_wb_t                                     wb,
    input  logic                                                  issue,
    input  rrag_pkg::tag_t                                        issue_tag,
    input  logic [isa_pkg::num_regs-1:0]                          dest_mask,
    input  logic                                                  ptc_clear,
    output logic [rrag_pkg::gpr_ports-1:0][isa_pkg::gpr_w-1:0]    rd_data,
    output logic [rrag_pkg::gpr_ports-1:0]                        rd_pend
);
    import isa_pkg::*;
    import rrag_pkg::*;

    logic [gpr_w-1:0]    regs_q [num_regs];
    tag_t                tag_q  [num_regs];
    logic [num_regs-1:0] pend_q;
    logic [num_regs-1:0] wb_hit;

    always_comb begin
        for (int i = 0; i < num_regs; i++) begin
            wb_hit[i] = wb.en && (wb.addr == reg_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs_q[i] <= '0;
                tag_q[i]  <= '0;
            end
            pend_q <= '0;
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (wb_hit[i]) begin
                    regs_q[i] <= wb.data; // Data lands even when tag is stale.
                end
                if (ptc_clear) begin
                    pend_q[i] <= 1'b0;
                end else if (issue && dest_mask[i]) begin
                    pend_q[i] <= 1'b1; // New mark beats a same-cycle writeback.
                    tag_q[i]  <= issue_tag;
                end else if (wb_hit[i] && (wb.tag == tag_q[i])) begin
                    pend_q[i] <= 1'b0;
                end
            end
        end
    end

    // Reads see a same-cycle write only on the next cycle.
    always_comb begin
        for (int p = 0; p < gpr_ports; p++) begin
            rd_data[p] = regs_q[rd_addr[p]];
            rd_pend[p] = pend_q[rd_addr[p]];
        end
    end

endmodule

`default_nettype wire

// File: regfile/seg_file.sv
`timescale 1ns/10ps
`default_nettype none

module seg_file (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  isa_pkg::reg_idx_t [rrag_pkg::seg_ports-1:0]           rd_addr,
    input  rrag_pkg::seg_wb_t                                     wb,
    input  logic                                                  issue,
    input  rrag_pkg::tag_t                                        issue_tag,
    input  logic [isa_pkg::num_regs-1:0]                          dest_mask,
    input  logic                                                  ptc_clear,
    output logic [rrag_pkg::seg_ports-1:0][isa_pkg::seg_w-1:0]    rd_data,
    output logic [rrag_pkg::seg_ports-1:0]                        rd_pend
);
    import isa_pkg::*;
    import rrag_pkg::*;

    logic [seg_w-1:0]    segs_q [num_regs];
    tag_t                tag_q  [num_regs];
    logic [num_regs-1:0] pend_q;
    logic [num_regs-1:0] wb_hit;

    always_comb begin
        for (int i = 0; i < num_regs; i++) begin
            wb_hit[i] = wb.en && (wb.addr == reg_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                segs_q[i] <= '0;
                tag_q[i]  <= '0;
            end
            pend_q <= '0;
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (wb_hit[i]) begin
                    segs_q[i] <= wb.data;
                end
                if (ptc_clear) begin
                    pend_q[i] <= 1'b0; // Flush drops all marks.
                end else if (issue && dest_mask[i]) begin
                    pend_q[i] <= 1'b1;
                    tag_q[i]  <= issue_tag;
                end else if (wb_hit[i] && (wb.tag == tag_q[i])) begin
                    pend_q[i] <= 1'b0; // Only the youngest writer clears.
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < seg_ports; p++) begin
            rd_data[p] = segs_q[rd_addr[p]];
            rd_pend[p] = pend_q[rd_addr[p]];
        end
    end

endmodule

`default_nettype wire

// File: src.f
common/isa_pkg.sv
common/rrag_pkg.sv
regfile/gpr_file.sv
regfile/seg_file.sv
logic/addr_gen.sv
logic/rrag.sv
dv/rrag_chk.sv
dv/rrag_tb.sv
